// File: design/execute_unit.sv
`timescale 1ns/1ps

module execute_unit (
	input  logic                       clk,
	input  logic                       resetn,
	input  rv_core_pkg::decoded_insn_t dec,
	input  logic                       dec_valid,
	input  rv_core_pkg::operands_t     ops,
	input  logic                       ops_ready,
	output logic                       insn_complete,
	output rv_core_pkg::retire_t       retire
);
	import rv_core_pkg::*;

	word_t      op_a;
	word_t      op_b;
	word_t      alu_out;
	word_t      pc_plus4;
	word_t      target;
	word_t      rd_wdata;
	logic [4:0] shamt;
	logic       lt;
	logic       ltu;
	logic       cond;
	logic       taken;
	logic       trap;
	logic       halted;

	assign op_a     = ops.rs1;
	assign op_b     = (dec.cls == cls_op_imm) ? dec.imm : ops.rs2;
	assign shamt    = op_b[4:0];
	assign pc_plus4 = dec.pc + 32'd4;

	// shared by slt/sltu and the branches
	assign lt  = $signed(op_a) < $signed(op_b);
	assign ltu = op_a < op_b;

	always_comb begin
		case (dec.funct3)
			3'b000:  alu_out = (dec.cls == cls_op && dec.alt) ? op_a - op_b : op_a + op_b;
			3'b001:  alu_out = op_a << shamt;
			3'b010:  alu_out = word_t'(lt);
			3'b011:  alu_out = word_t'(ltu);
			3'b100:  alu_out = op_a ^ op_b;
			3'b101:  alu_out = dec.alt ? word_t'($signed(op_a) >>> shamt) : op_a >> shamt;
			3'b110:  alu_out = op_a | op_b;
			default: alu_out = op_a & op_b;
		endcase
	end

	always_comb begin
		case (dec.funct3)
			3'b000:  cond = (op_a == op_b);   // beq
			3'b001:  cond = (op_a != op_b);
			3'b100:  cond = lt;
			3'b101:  cond = !lt;
			3'b110:  cond = ltu;
			3'b111:  cond = !ltu;
			default: cond = 1'b0;
		endcase
	end

	always_comb begin
		taken    = 1'b0;
		target   = dec.pc + dec.imm;
		rd_wdata = pc_plus4;   // link value
		case (dec.cls)
			cls_lui:    rd_wdata = dec.imm;
			cls_auipc:  rd_wdata = dec.pc + dec.imm;
			cls_jal:    taken = 1'b1;
			cls_jalr: begin
				taken     = 1'b1;
				target    = op_a + dec.imm;
				target[0] = 1'b0;
			end
			cls_branch: taken = cond;
			cls_op:     rd_wdata = alu_out;
			cls_op_imm: rd_wdata = alu_out;
			default:    rd_wdata = '0;
		endcase
	end

	// misaligned taken target traps too
	assign trap = (dec.cls == cls_illegal) || (taken && target[1]);

	always_ff @(posedge clk) begin
		if (!resetn)
			halted <= 1'b0;
		else if (insn_complete && trap)
			halted <= 1'b1;   // stays until reset
	end

	assign insn_complete = dec_valid && ops_ready && !halted;

	assign retire.pc        = dec.pc;
	assign retire.pc_next   = trap ? dec.pc : (taken ? target : pc_plus4);
	assign retire.rd        = dec.rd;
	assign retire.rd_wdata  = rd_wdata;
	assign retire.writes_rd = dec.writes_rd && !trap;
	assign retire.trap      = trap;

endmodule

// File: design/fetch_decode.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module fetch_decode (
	input  logic                       clk,
	input  logic                       resetn,
	input  rv_core_pkg::word_t         insn,
	input  logic                       insn_valid,
	input  logic                       insn_complete,
	input  rv_core_pkg::word_t         next_pc,
	output rv_core_pkg::word_t         insn_addr,
	output rv_core_pkg::decoded_insn_t dec,
	output logic                       dec_valid
);
	import rv_core_pkg::*;

	localparam logic [6:0] opc_lui    = 7'b0110111;
	localparam logic [6:0] opc_auipc  = 7'b0010111;
	localparam logic [6:0] opc_jal    = 7'b1101111;
	localparam logic [6:0] opc_jalr   = 7'b1100111;
	localparam logic [6:0] opc_branch = 7'b1100011;
	localparam logic [6:0] opc_op     = 7'b0110011;
	localparam logic [6:0] opc_op_imm = 7'b0010011;

	word_t      pc;
	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i;
	word_t      imm_u;
	word_t      imm_j;
	word_t      imm_b;
	logic       op_legal;
	logic       op_imm_legal;

	always_ff @(posedge clk) begin
		if (!resetn)
			pc <= `RV_RESET_PC;
		else if (insn_complete)
			pc <= next_pc;
	end

	assign insn_addr = {pc[`RV_XLEN-1:1], 1'b0};
	assign dec_valid = insn_valid;

	assign opcode = insn[6:0];
	assign funct3 = insn[14:12];
	assign funct7 = insn[31:25];

	// immediate formats
	assign imm_i = {{20{insn[31]}}, insn[31:20]};
	assign imm_u = {insn[31:12], 12'b0};
	assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
	assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};

	// sub and sra are the only alternate encodings
	assign op_legal = (funct7 == 7'b0000000) ||
		((funct7 == 7'b0100000) && (funct3 == 3'b000 || funct3 == 3'b101));

	always_comb begin
		case (funct3)
			3'b001:  op_imm_legal = (funct7 == 7'b0000000);   // slli
			3'b101:  op_imm_legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
			default: op_imm_legal = 1'b1;
		endcase
	end

	always_comb begin
		dec        = '0;
		dec.cls    = cls_illegal;
		dec.funct3 = funct3;
		dec.alt    = insn[30];
		dec.rd     = insn[11:7];
		dec.rs1    = insn[19:15];
		dec.rs2    = insn[24:20];
		dec.pc     = insn_addr;
		case (opcode)
			opc_lui: begin
				dec.cls       = cls_lui;
				dec.imm       = imm_u;
				dec.writes_rd = 1'b1;
			end
			opc_auipc: begin
				dec.cls       = cls_auipc;
				dec.imm       = imm_u;
				dec.writes_rd = 1'b1;
			end
			opc_jal: begin
				dec.cls       = cls_jal;
				dec.imm       = imm_j;
				dec.writes_rd = 1'b1;
			end
			opc_jalr: if (funct3 == 3'b000) begin
				dec.cls       = cls_jalr;
				dec.imm       = imm_i;
				dec.uses_rs1  = 1'b1;
				dec.writes_rd = 1'b1;
			end
			opc_branch: if (funct3 != 3'b010 && funct3 != 3'b011) begin
				dec.cls      = cls_branch;
				dec.imm      = imm_b;
				dec.uses_rs1 = 1'b1;
				dec.uses_rs2 = 1'b1;
			end
			opc_op: if (op_legal) begin
				dec.cls       = cls_op;
				dec.uses_rs1  = 1'b1;
				dec.uses_rs2  = 1'b1;
				dec.writes_rd = 1'b1;
			end
			opc_op_imm: if (op_imm_legal) begin
				dec.cls       = cls_op_imm;
				dec.imm       = imm_i;   // shamt sits in the low bits
				dec.uses_rs1  = 1'b1;
				dec.writes_rd = 1'b1;
			end
			default: dec.cls = cls_illegal;   // unknown opcode without flags
		endcase
	end

endmodule

// File: design/operand_fetch.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module operand_fetch (
	input  logic                       clk,
	input  logic                       resetn,
	input  rv_core_pkg::decoded_insn_t dec,
	input  logic                       dec_valid,
	input  logic                       insn_complete,
	input  rv_core_pkg::reg_addr_t     wb_rd,
	input  rv_core_pkg::word_t         wb_data,
	input  logic                       wb_en,
	output rv_core_pkg::operands_t     ops,
	output logic                       ops_ready
);
	import rv_core_pkg::*;

	localparam int read_delay = `RV_REG_READ_DELAY;

	typedef enum logic [1:0] {st_idle, st_requested, st_latched} opnd_state_e;

	word_t       regs [`RV_NUM_REGS];
	opnd_state_e state [2];   // index 0 is rs1 and 1 is rs2
	word_t       opnd [2];
	reg_addr_t   src [2];
	logic [1:0]  need;
	logic [1:0]  req;
	logic [1:0]  grant;
	reg_addr_t   rd_addr;
	word_t       rd_data;
	word_t       data_pipe [read_delay];
	logic [1:0]  tag_pipe [read_delay];
	word_t       data_out;
	logic [1:0]  tag_out;

	assign src[0] = dec.rs1;
	assign src[1] = dec.rs2;

	// x0 is never read and comes out as zero
	assign need[0] = dec_valid && dec.uses_rs1 && (dec.rs1 != '0);
	assign need[1] = dec_valid && dec.uses_rs2 && (dec.rs2 != '0);

	always_comb begin
		for (int i = 0; i < 2; i++)
			req[i] = need[i] && (state[i] == st_idle);
	end

	// fixed priority arbiter where rs1 wins
	assign grant[0] = req[0];
	assign grant[1] = req[1] && !req[0];

	assign rd_addr = grant[0] ? src[0] : src[1];
	assign rd_data = regs[rd_addr];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			regs[0] <= '0;
			regs[2] <= `RV_STACK_ADDR;
		end else if (insn_complete && wb_en && wb_rd != '0) begin
			regs[wb_rd] <= wb_data;
		end
	end

	// read data delay line
	always_ff @(posedge clk) begin
		data_pipe[0] <= rd_data;
		for (int s = 1; s < read_delay; s++)
			data_pipe[s] <= data_pipe[s-1];
	end

	// one-hot tag travels alongside the data
	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int s = 0; s < read_delay; s++)
				tag_pipe[s] <= '0;
		end else begin
			tag_pipe[0] <= grant;
			for (int s = 1; s < read_delay; s++)
				tag_pipe[s] <= tag_pipe[s-1];
		end
	end

	assign data_out = data_pipe[read_delay-1];
	assign tag_out  = tag_pipe[read_delay-1];

	always_ff @(posedge clk) begin
		if (!resetn) begin
			for (int i = 0; i < 2; i++)
				state[i] <= st_idle;
		end else begin
			for (int i = 0; i < 2; i++) begin
				if (insn_complete)
					state[i] <= st_idle;   // latches free for the next insn
				else if (grant[i])
					state[i] <= st_requested;
				else if (tag_out[i] && state[i] == st_requested)
					state[i] <= st_latched;
			end
		end
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < 2; i++) begin
			if (tag_out[i])
				opnd[i] <= data_out;
		end
	end

	assign ops.rs1 = (dec.rs1 == '0) ? '0 : opnd[0];
	assign ops.rs2 = (dec.rs2 == '0) ? '0 : opnd[1];

	assign ops_ready = (!need[0] || state[0] == st_latched) &&
		(!need[1] || state[1] == st_latched);

endmodule

// File: design/rv_core_pkg.sv
`include "rv_core_params.svh"

package rv_core_pkg;

	typedef logic [`RV_XLEN-1:0] word_t;
	typedef logic [$clog2(`RV_NUM_REGS)-1:0] reg_addr_t;

	// instruction classes kept by the core
	typedef enum logic [2:0] {
		cls_lui,
		cls_auipc,
		cls_jal,
		cls_jalr,
		cls_branch,
		cls_op,
		cls_op_imm,
		cls_illegal
	} insn_class_e;

	typedef struct packed {
		insn_class_e cls;
		logic [2:0]  funct3;
		logic        alt;       // funct7 bit 5 for sub and sra
		reg_addr_t   rd;
		reg_addr_t   rs1;
		reg_addr_t   rs2;
		word_t       imm;       // already sign extended
		word_t       pc;
		logic        uses_rs1;
		logic        uses_rs2;
		logic        writes_rd;
	} decoded_insn_t;

	typedef struct packed {
		word_t rs1;
		word_t rs2;
	} operands_t;

	// one completed instruction
	typedef struct packed {
		word_t     pc;
		word_t     pc_next;
		reg_addr_t rd;
		word_t     rd_wdata;
		logic      writes_rd;
		logic      trap;
	} retire_t;

endpackage

// File: design/rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
	input  logic                 clk,
	input  logic                 resetn,
	input  rv_core_pkg::word_t   insn,
	input  logic                 insn_valid,
	output rv_core_pkg::word_t   insn_addr,
	output logic                 insn_complete,
	output logic                 retire_valid,
	output rv_core_pkg::retire_t retire
);
	import rv_core_pkg::*;

	decoded_insn_t dec;
	logic          dec_valid;
	operands_t     ops;
	logic          ops_ready;

	// every completion retires
	assign retire_valid = insn_complete;

	fetch_decode fetch_decode_inst (
		.clk           (clk),
		.resetn        (resetn),
		.insn          (insn),
		.insn_valid    (insn_valid),
		.insn_complete (insn_complete),
		.next_pc       (retire.pc_next),
		.insn_addr     (insn_addr),
		.dec           (dec),
		.dec_valid     (dec_valid)
	);

	operand_fetch operand_fetch_inst (
		.clk           (clk),
		.resetn        (resetn),
		.dec           (dec),
		.dec_valid     (dec_valid),
		.insn_complete (insn_complete),
		.wb_rd         (retire.rd),
		.wb_data       (retire.rd_wdata),
		.wb_en         (retire.writes_rd),
		.ops           (ops),
		.ops_ready     (ops_ready)
	);

	execute_unit execute_unit_inst (
		.clk           (clk),
		.resetn        (resetn),
		.dec           (dec),
		.dec_valid     (dec_valid),
		.ops           (ops),
		.ops_ready     (ops_ready),
		.insn_complete (insn_complete),
		.retire        (retire)
	);

endmodule

// File: filelist.f
+incdir+include
design/rv_core_pkg.sv
design/fetch_decode.sv
design/operand_fetch.sv
design/execute_unit.sv
design/rv_core_top.sv
verification/tb_clock_gen.sv
verification/rv_core_sva.sv
verification/rv_core_tb.sv

// File: include/rv_core_params.svh
`ifndef RV_CORE_PARAMS_SVH
`define RV_CORE_PARAMS_SVH

// data path width
`define RV_XLEN 32

// integer register count, x0 included
`define RV_NUM_REGS 32

// cycles from a read grant until its data leaves the read pipeline
`define RV_REG_READ_DELAY 3

// program counter after reset
`define RV_RESET_PC 32'h0001_0000

// x2 after reset
`define RV_STACK_ADDR 32'h0001_0000

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the core testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -j 0 \
	--top-module rv_core_tb \
	-f filelist.f \
	-o rv_core_sim

# a raised error limit lets assertion failures reach the testbench
./obj_dir/rv_core_sim +verilator+error+limit+100 2>&1 | tee sim.log

if grep -q "ALL CHECKS PASSED" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi

// File: verification/rv_core_sva.sv
`timescale 1ns/1ps

module rv_core_sva (
	input logic                 clk,
	input logic                 resetn,
	input logic                 insn_valid,
	input rv_core_pkg::word_t   insn_addr,
	input logic                 insn_complete,
	input rv_core_pkg::retire_t retire
);

	int   fail_count = 0;
	logic trapped;   // a trap has retired since reset

	always_ff @(posedge clk) begin
		if (!resetn)
			trapped <= 1'b0;
		else if (insn_complete && retire.trap)
			trapped <= 1'b1;
	end

	complete_needs_valid: assert property (@(posedge clk) disable iff (!resetn)
		insn_complete |-> insn_valid)
		else begin
			fail_count++;
			$error("insn_complete high without insn_valid");
		end

	addr_aligned: assert property (@(posedge clk) disable iff (!resetn)
		insn_addr[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("insn_addr not word aligned");
		end

	// halted core stays quiet until the next reset
	no_complete_after_trap: assert property (@(posedge clk) disable iff (!resetn)
		trapped |-> !insn_complete)
		else begin
			fail_count++;
			$error("completion after a trap");
		end

	trap_without_write: assert property (@(posedge clk) disable iff (!resetn)
		insn_complete |-> !(retire.trap && retire.writes_rd))
		else begin
			fail_count++;
			$error("trap retired together with a register write");
		end

endmodule

// File: verification/rv_core_tb.sv
`timescale 1ns/1ps
`include "rv_core_params.svh"

module rv_core_tb;
	import rv_core_pkg::*;

	localparam int n_init       = 62;
	localparam int n_random     = 300;
	localparam int n_ctrl       = 120;
	localparam int n_b2b        = 60;
	localparam int reset_cycles = 10;
	localparam int hold_cycles  = 20;
	localparam int n_total      = 2 + n_init + n_random + n_ctrl + 2 + n_b2b;
	// 6 cycles per insn worst case plus three resets and two trap holds and a margin
	localparam int cycle_limit  = 6 * n_total + 3 * (reset_cycles + 1) + 2 * hold_cycles + 100;

	logic    clk;
	logic    resetn;
	logic    insn_valid;
	word_t   insn;
	word_t   insn_addr;
	logic    insn_complete;
	logic    retire_valid;
	retire_t retire;

	word_t       model_regs [32];
	word_t       model_pc;
	retire_t     last_retire;
	logic [31:0] lfsr;
	int          cycles = 0;

	tb_clock_gen clock_gen_inst (.clk(clk));

	rv_core_top rv_core_top_inst (
		.clk           (clk),
		.resetn        (resetn),
		.insn          (insn),
		.insn_valid    (insn_valid),
		.insn_addr     (insn_addr),
		.insn_complete (insn_complete),
		.retire_valid  (retire_valid),
		.retire        (retire)
	);

	bind rv_core_top rv_core_sva rv_core_sva_inst (
		.clk           (clk),
		.resetn        (resetn),
		.insn_valid    (insn_valid),
		.insn_addr     (insn_addr),
		.insn_complete (insn_complete),
		.retire        (retire)
	);

	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_val(input string name, input word_t got, input word_t want);
		if (got !== want) begin
			$display("[ERROR] %s: got 0x%08h, expected 0x%08h", name, got, want);
			abort_run();
		end
	endtask

	// x^32 + x^22 + x^2 + x + 1 with one step per bit
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		logic        fb;
		v = '0;
		for (int i = 0; i < n; i++) begin
			fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
			lfsr = {lfsr[30:0], fb};
			v    = {v[30:0], fb};
		end
		return v;
	endfunction

	function automatic word_t enc_r(logic [6:0] f7, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3, logic [4:0] rd);
		return {f7, rs2, rs1, f3, rd, 7'b0110011};
	endfunction

	function automatic word_t enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] opc);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic word_t enc_u(logic [19:0] imm, logic [4:0] rd, logic [6:0] opc);
		return {imm, rd, opc};
	endfunction

	function automatic word_t enc_j(logic [20:0] imm, logic [4:0] rd);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	function automatic word_t enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
			logic [2:0] f3);
		return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
		case (f3)
			3'd0:    return alt ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'b0, $signed(a) < $signed(b)};
			3'd3:    return {31'b0, a < b};
			3'd4:    return a ^ b;
			3'd5:    return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	// reference behavior of one instruction at model_pc
	function automatic retire_t model_exec(word_t w);
		retire_t    e;
		word_t      a;
		word_t      b;
		word_t      imm_i;
		word_t      res;
		word_t      tgt;
		logic [2:0] f3;
		logic [6:0] f7;
		logic       jump;
		logic       ill;
		f3    = w[14:12];
		f7    = w[31:25];
		a     = model_regs[w[19:15]];
		b     = model_regs[w[24:20]];
		imm_i = {{20{w[31]}}, w[31:20]};
		jump  = 1'b0;
		ill   = 1'b0;
		tgt   = '0;
		res   = model_pc + 32'd4;   // link value
		e     = '0;
		e.pc  = model_pc;
		e.rd  = w[11:7];
		e.writes_rd = 1'b1;
		case (w[6:0])
			7'b0110111: res = {w[31:12], 12'b0};
			7'b0010111: res = model_pc + {w[31:12], 12'b0};
			7'b1101111: begin
				jump = 1'b1;
				tgt  = model_pc + {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
			end
			7'b1100111: begin
				ill  = (f3 != 3'd0);
				jump = 1'b1;
				tgt  = (a + imm_i) & ~32'd1;
			end
			7'b1100011: begin
				e.writes_rd = 1'b0;
				tgt = model_pc + {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
				case (f3)
					3'd0:    jump = (a == b);
					3'd1:    jump = (a != b);
					3'd4:    jump = $signed(a) < $signed(b);
					3'd5:    jump = $signed(a) >= $signed(b);
					3'd6:    jump = a < b;
					3'd7:    jump = a >= b;
					default: ill = 1'b1;
				endcase
			end
			7'b0110011: begin
				ill = !(f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5)));
				res = alu_ref(f3, f7[5], a, b);
			end
			7'b0010011: begin
				ill = (f3 == 3'd1 && f7 != 7'h00) ||
					(f3 == 3'd5 && f7 != 7'h00 && f7 != 7'h20);
				res = alu_ref(f3, f3 == 3'd5 && f7[5], a, imm_i);
			end
			default: ill = 1'b1;
		endcase
		e.trap      = ill || (jump && tgt[1]);
		e.writes_rd = e.writes_rd && !e.trap;
		e.rd_wdata  = res;
		e.pc_next   = e.trap ? model_pc : (jump ? tgt : model_pc + 32'd4);
		return e;
	endfunction

	function automatic word_t rand_alu_insn();
		logic [2:0]  f3;
		logic        alt;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [11:0] imm;
		f3  = 3'(take_bits(3));
		alt = 1'(take_bits(1));
		rd  = 5'(take_bits(5));
		rs1 = 5'(take_bits(5));
		rs2 = 5'(take_bits(5));
		if (take_bits(1) == 32'd1)
			return enc_r((alt && (f3 == 3'd0 || f3 == 3'd5)) ? 7'h20 : 7'h00, rs2, rs1, f3, rd);
		imm = 12'(take_bits(12));
		if (f3 == 3'd1)
			imm[11:5] = 7'h00;   // slli
		else if (f3 == 3'd5)
			imm[11:5] = alt ? 7'h20 : 7'h00;
		return enc_i(imm, rs1, f3, rd, 7'b0010011);
	endfunction

	// auipc, jal, jalr or branch with word aligned targets
	function automatic word_t rand_ctrl_insn();
		logic [1:0]  kind;
		logic [4:0]  rd;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [2:0]  f3;
		logic [20:0] jimm;
		logic [12:0] bimm;
		logic [11:0] iimm;
		word_t       sum;
		kind = 2'(take_bits(2));
		rd   = 5'(take_bits(5));
		rs1  = 5'(take_bits(5));
		rs2  = 5'(take_bits(5));
		case (kind)
			2'd0: return enc_u(20'(take_bits(20)), rd, 7'b0010111);
			2'd1: begin
				jimm      = 21'(take_bits(21));
				jimm[1:0] = 2'b00;
				return enc_j(jimm, rd);
			end
			2'd2: begin
				iimm = 12'(take_bits(12));
				sum  = model_regs[rs1] + {{20{iimm[11]}}, iimm};
				if (sum[1])
					iimm[1] = ~iimm[1];   // flips bit 1 of the target
				return enc_i(iimm, rs1, 3'b000, rd, 7'b1100111);
			end
			default: begin
				f3 = 3'(take_bits(3));
				if (f3 == 3'd2 || f3 == 3'd3)
					f3 = f3 + 3'd2;
				bimm      = 13'(take_bits(13));
				bimm[1:0] = 2'b00;
				if (take_bits(2) == 32'd0)
					rs2 = rs1;   // equal operands now and then
				return enc_b(bimm, rs2, rs1, f3);
			end
		endcase
	endfunction

	task automatic wait_complete();
		#1;
		while (!insn_complete) begin
			@(negedge clk);
			#1;
		end
	endtask

	task automatic run_insn(input word_t w);
		retire_t want;
		check_val("insn_addr", insn_addr, model_pc);
		insn       = w;
		insn_valid = 1'b1;
		want       = model_exec(w);
		wait_complete();
		last_retire = retire;
		check_val("retire_valid", 32'(retire_valid), 32'd1);
		check_val("retire.pc", retire.pc, want.pc);
		check_val("retire.pc_next", retire.pc_next, want.pc_next);
		check_val("retire.trap", 32'(retire.trap), 32'(want.trap));
		check_val("retire.writes_rd", 32'(retire.writes_rd), 32'(want.writes_rd));
		if (want.writes_rd) begin
			check_val("retire.rd", 32'(retire.rd), 32'(want.rd));
			check_val("retire.rd_wdata", retire.rd_wdata, want.rd_wdata);
			if (want.rd != '0)
				model_regs[want.rd] = want.rd_wdata;
		end
		model_pc = want.pc_next;
		@(negedge clk);
	endtask

	task automatic apply_reset();
		resetn     = 1'b0;
		insn_valid = 1'b0;
		repeat (reset_cycles) @(negedge clk);
		resetn        = 1'b1;
		model_regs[0] = '0;
		model_regs[2] = `RV_STACK_ADDR;   // other registers keep their values
		model_pc      = `RV_RESET_PC;
		#1;
		check_val("insn_addr", insn_addr, `RV_RESET_PC);
		check_val("insn_complete", 32'(insn_complete), 32'd0);
		check_val("retire_valid", 32'(retire_valid), 32'd0);
		@(negedge clk);
	endtask

	task automatic check_stack_copy();
		run_insn(enc_r(7'h00, 5'd0, 5'd2, 3'd0, 5'd1));   // add x1, x2, x0
		check_val("retire.rd_wdata", last_retire.rd_wdata, `RV_STACK_ADDR);
	endtask

	task automatic hold_after_trap();
		repeat (hold_cycles) begin
			#1;
			if (insn_complete) begin
				$display("core completed an instruction while halted after a trap");
				abort_run();
			end
			@(negedge clk);
		end
	endtask

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout after %0d cycles, the core stopped completing instructions",
				cycle_limit);
			abort_run();
		end
		if (rv_core_top_inst.rv_core_sva_inst.fail_count != 0) begin
			$display("an assertion bound to rv_core_top failed");
			abort_run();
		end
	end

	initial begin
		word_t      w;
		logic [4:0] rd;
		logic [4:0] prev_rd;
		lfsr       = 32'd35;
		resetn     = 1'b0;
		insn_valid = 1'b0;
		insn       = '0;
		model_pc   = '0;
		for (int r = 0; r < 32; r++)
			model_regs[r] = '0;

		apply_reset();
		check_stack_copy();

		// every register gets a known value
		for (int r = 1; r < 32; r++) begin
			run_insn(enc_u(20'(take_bits(20)), 5'(r), 7'b0110111));
			run_insn(enc_i(12'(take_bits(12)), 5'(r), 3'b000, 5'(r), 7'b0010011));
		end
		repeat (n_random) run_insn(rand_alu_insn());

		repeat (n_ctrl) run_insn(rand_ctrl_insn());

		// an illegal opcode and a misaligned jal that each end in a reset
		w      = take_bits(32);
		w[6:0] = 7'b0001011;
		run_insn(w);
		hold_after_trap();
		apply_reset();
		w         = take_bits(32);
		w[6:0]    = 7'b1101111;
		w[22:21]  = 2'b01;   // offset bit 1
		w[11:7]   = 5'd5;
		run_insn(w);
		hold_after_trap();
		apply_reset();
		check_stack_copy();

		// each insn reads the register written just before it
		prev_rd = 5'd1;
		for (int i = 0; i < n_b2b; i++) begin
			w        = rand_alu_insn();
			w[19:15] = prev_rd;
			if (w[6:0] == 7'b0110011 && take_bits(1) == 32'd1)
				w[24:20] = prev_rd;
			rd = 5'(take_bits(5));
			if (rd == 5'd0)
				rd = 5'd3;
			w[11:7] = rd;
			run_insn(w);
			prev_rd = rd;
		end

		#1;
		if (rv_core_top_inst.rv_core_sva_inst.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int half_period = 2   // half of the 4 ns clock in ns
) (
	output logic clk
);

	initial clk = 1'b0;

	always #half_period clk = ~clk;

endmodule
